/* Makefile */
VERILATOR ?= verilator
TOP       := tb_lcd_top
FILELIST  := files.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
LINTFLAGS := --lint-only -Wall --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# a $fatal in the testbench gives a non-zero exit status
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* files.f */
hdl/lcd_timing_pkg.sv
hdl/lcd_cmd_pkg.sv
hdl/lcd_timer_if.sv
hdl/lcd_wait_timer.sv
hdl/lcd_sequencer.sv
hdl/lcd_bus_driver.sv
hdl/lcd_top.sv
tests/tb_lcd_top.sv

/* hdl/lcd_bus_driver.sv */
`timescale 1ns/1ps

module lcd_bus_driver (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              capture,
    input  logic                              load,
    input  lcd_cmd_pkg::bus_sel_t             sel,
    input  logic [7:0]                        cmd_code,
    input  logic                              e_active,
    input  logic                              row,
    input  logic [lcd_cmd_pkg::COL_W-1:0]     col,
    input  logic [7:0]                        char_code,
    output logic                              lcd_e,
    output logic                              lcd_rs,
    output logic                              lcd_rw,
    output logic [7:0]                        lcd_data
);
    import lcd_cmd_pkg::*;

    logic             row_q;
    logic [COL_W-1:0] col_q;
    logic [7:0]       char_q;
    lcd_word_u        word;

    // request payload, held for both steps
    always_ff @(posedge clk) begin
        if (capture) begin
            row_q  <= row;
            col_q  <= col;
            char_q <= char_code;
        end
    end

    always_comb begin
        word = '0;
        case (sel)
            sel_addr: begin
                word.ddram.set_flag = 1'b1;
                word.ddram.addr     = (row_q ? LINE2_BASE : LINE1_BASE) + 7'(col_q);
            end
            sel_char: word.instr = char_q;
            default:  word.instr = cmd_code;
        endcase
    end

    // ========================================
    // pin registers
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lcd_e    <= 1'b0;
            lcd_rs   <= 1'b0;
            lcd_data <= 8'h00;
        end else begin
            lcd_e <= e_active;
            if (load) begin
                lcd_rs   <= (sel == sel_char);
                lcd_data <= word.instr;
            end
        end
    end

    assign lcd_rw = 1'b0;  // write only

    a_rs_only_for_char: assert property (@(posedge clk) disable iff (!rst_n)
        lcd_e |-> (lcd_rs == (sel == sel_char)));

endmodule

/* hdl/lcd_cmd_pkg.sv */
package lcd_cmd_pkg;

    // ========================================
    // HD44780 instruction codes, 8-bit mode
    // ========================================
    localparam logic [7:0] CMD_WAKEUP     = 8'h30;
    localparam logic [7:0] CMD_FUNC_SET   = 8'h38;  // 8-bit, 2 lines, 5x8 font
    localparam logic [7:0] CMD_DISP_OFF   = 8'h08;
    localparam logic [7:0] CMD_DISP_CLEAR = 8'h01;
    localparam logic [7:0] CMD_ENTRY_MODE = 8'h06;  // increment, no shift
    localparam logic [7:0] CMD_DISP_ON    = 8'h0C;  // cursor off

    // DDRAM start of each display line
    localparam logic [6:0] LINE1_BASE = 7'h00;
    localparam logic [6:0] LINE2_BASE = 7'h40;

    // 16 columns per line
    localparam int COL_W = 4;

    // ========================================
    // bus word
    // ========================================
    // same byte seen as a plain instruction or as set DDRAM address
    typedef union packed {
        logic [7:0] instr;
        struct packed {
            logic       set_flag;  // bit 7, marks set-address
            logic [6:0] addr;
        } ddram;
    } lcd_word_u;

    // what the bus driver puts on the pins for a step
    typedef enum logic [1:0] {
        sel_cmd,
        sel_addr,
        sel_char
    } bus_sel_t;

endpackage

/* hdl/lcd_sequencer.sv */
`timescale 1ns/1ps

module lcd_sequencer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req,
    output logic                  busy,
    output logic                  done,
    output logic                  capture,
    output logic                  load,
    output lcd_cmd_pkg::bus_sel_t sel,
    output logic [7:0]            cmd_code,
    lcd_timer_if.seq              tmr_bus
);
    import lcd_timing_pkg::*;
    import lcd_cmd_pkg::*;

    // ========================================
    // states
    // ========================================
    localparam logic [3:0] ST_PWR_WAIT   = 4'd0;
    localparam logic [3:0] ST_INIT_1     = 4'd1;
    localparam logic [3:0] ST_INIT_2     = 4'd2;
    localparam logic [3:0] ST_INIT_3     = 4'd3;
    localparam logic [3:0] ST_FUNC_SET   = 4'd4;
    localparam logic [3:0] ST_DISP_OFF   = 4'd5;
    localparam logic [3:0] ST_DISP_CLR   = 4'd6;
    localparam logic [3:0] ST_ENTRY_MODE = 4'd7;
    localparam logic [3:0] ST_DISP_ON    = 4'd8;
    localparam logic [3:0] ST_IDLE       = 4'd9;
    localparam logic [3:0] ST_SET_ADDR   = 4'd10;
    localparam logic [3:0] ST_WRITE_CHAR = 4'd11;

    logic [3:0] state;
    logic [3:0] next_state;
    logic       issued;     // start already sent for this state
    wait_kind_t step_kind;

    // per-state step description
    always_comb begin
        step_kind  = command;
        sel        = sel_cmd;
        cmd_code   = 8'h00;
        next_state = ST_IDLE;
        case (state)
            ST_PWR_WAIT: begin
                step_kind  = power_up;
                next_state = ST_INIT_1;
            end
            ST_INIT_1: begin
                step_kind  = wake_long;
                cmd_code   = CMD_WAKEUP;
                next_state = ST_INIT_2;
            end
            ST_INIT_2: begin
                step_kind  = wake_short;
                cmd_code   = CMD_WAKEUP;
                next_state = ST_INIT_3;
            end
            ST_INIT_3: begin
                cmd_code   = CMD_WAKEUP;
                next_state = ST_FUNC_SET;
            end
            ST_FUNC_SET: begin
                cmd_code   = CMD_FUNC_SET;
                next_state = ST_DISP_OFF;
            end
            ST_DISP_OFF: begin
                cmd_code   = CMD_DISP_OFF;
                next_state = ST_DISP_CLR;
            end
            ST_DISP_CLR: begin
                step_kind  = clear;
                cmd_code   = CMD_DISP_CLEAR;
                next_state = ST_ENTRY_MODE;
            end
            ST_ENTRY_MODE: begin
                cmd_code   = CMD_ENTRY_MODE;
                next_state = ST_DISP_ON;
            end
            ST_DISP_ON: begin
                cmd_code   = CMD_DISP_ON;
                next_state = ST_IDLE;
            end
            ST_SET_ADDR: begin
                sel        = sel_addr;  // address built in the bus driver
                next_state = ST_WRITE_CHAR;
            end
            ST_WRITE_CHAR: begin
                sel        = sel_char;
                next_state = ST_IDLE;
            end
            default: next_state = ST_IDLE;
        endcase
    end

    // one kick per step, first cycle in the state
    assign load          = (state != ST_IDLE) && !issued;
    assign tmr_bus.start = load;
    assign tmr_bus.kind  = step_kind;
    assign capture       = (state == ST_IDLE) && req;

    // ========================================
    // state register
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= ST_PWR_WAIT;
            issued <= 1'b0;
            busy   <= 1'b1;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            if (state == ST_IDLE) begin
                if (req) begin
                    busy  <= 1'b1;
                    state <= ST_SET_ADDR;
                end
            end else if (!issued) begin
                issued <= 1'b1;
            end else if (tmr_bus.step_done) begin
                state  <= next_state;
                issued <= 1'b0;
                if (next_state == ST_IDLE)
                    busy <= 1'b0;  // end of init or of a write
                if (state == ST_WRITE_CHAR)
                    done <= 1'b1;
            end
        end
    end

    a_done_after_char: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> ($past(state) == ST_WRITE_CHAR && state == ST_IDLE));

endmodule

/* hdl/lcd_timer_if.sv */
`timescale 1ns/1ps

interface lcd_timer_if;
    import lcd_timing_pkg::*;

    logic       start;      // one-cycle kick, timer must be idle
    wait_kind_t kind;       // hold time for the step
    logic       e_active;   // inside the strobe window
    logic       step_done;  // last counting cycle

    modport seq (
        output start,
        output kind,
        input  e_active,
        input  step_done
    );

    modport tmr (
        input  start,
        input  kind,
        output e_active,
        output step_done
    );

endinterface

/* hdl/lcd_timing_pkg.sv */
package lcd_timing_pkg;

    // ========================================
    // step hold times
    // ========================================
    typedef enum logic [2:0] {
        power_up,    // supply settle, no E strobe
        wake_long,   // after first 0x30
        wake_short,  // after second 0x30
        command,     // normal instruction or data write
        clear        // display clear needs the long one
    } wait_kind_t;

    // E strobe window, in counter ticks from step start
    localparam int E_PULSE_START = 2;
    localparam int E_PULSE_END   = 22;

    function automatic int unsigned wait_us(input wait_kind_t kind);
        case (kind)
            power_up:   return 15000;
            wake_long:  return 5000;
            wake_short: return 100;
            clear:      return 2000;
            default:    return 50;
        endcase
    endfunction

    // only the power-up wait runs without a strobe
    function automatic logic has_e_pulse(input wait_kind_t kind);
        return kind != power_up;
    endfunction

endpackage

/* hdl/lcd_top.sv */
`timescale 1ns/1ps

module lcd_top #(
    parameter int CLK_HZ = 25_000_000
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req,
    input  logic                          row,
    input  logic [lcd_cmd_pkg::COL_W-1:0] col,
    input  logic [7:0]                    char_code,
    output logic                          busy,
    output logic                          done,
    output logic                          lcd_e,
    output logic                          lcd_rs,
    output logic                          lcd_rw,
    output logic [7:0]                    lcd_data
);
    import lcd_cmd_pkg::*;

    // ========================================
    // internal wiring
    // ========================================
    lcd_timer_if tmr_if ();

    logic       capture;
    logic       load;
    bus_sel_t   sel;
    logic [7:0] cmd_code;

    lcd_sequencer u_seq (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .busy     (busy),
        .done     (done),
        .capture  (capture),
        .load     (load),
        .sel      (sel),
        .cmd_code (cmd_code),
        .tmr_bus  (tmr_if.seq)
    );

    lcd_wait_timer #(
        .CLK_HZ (CLK_HZ)
    ) u_tmr (
        .clk     (clk),
        .rst_n   (rst_n),
        .tmr_bus (tmr_if.tmr)
    );

    // pins
    lcd_bus_driver u_drv (
        .clk       (clk),
        .rst_n     (rst_n),
        .capture   (capture),
        .load      (load),
        .sel       (sel),
        .cmd_code  (cmd_code),
        .e_active  (tmr_if.e_active),
        .row       (row),
        .col       (col),
        .char_code (char_code),
        .lcd_e     (lcd_e),
        .lcd_rs    (lcd_rs),
        .lcd_rw    (lcd_rw),
        .lcd_data  (lcd_data)
    );

endmodule

/* hdl/lcd_wait_timer.sv */
`timescale 1ns/1ps

module lcd_wait_timer #(
    parameter int CLK_HZ = 25_000_000
) (
    input  logic       clk,
    input  logic       rst_n,
    lcd_timer_if.tmr   tmr_bus
);
    import lcd_timing_pkg::*;

    localparam int CYC_PER_US = CLK_HZ / 1_000_000;
    // sized for the longest step, the power-up wait
    localparam int CNT_W = $clog2(E_PULSE_END + wait_us(power_up) * CYC_PER_US + 1);

    logic             running;
    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] end_cnt;
    wait_kind_t       kind_q;

    // strobe window first, then the hold time
    assign end_cnt = CNT_W'(E_PULSE_END + wait_us(kind_q) * CYC_PER_US);

    // ========================================
    // step counter
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            cnt     <= '0;
            kind_q  <= power_up;
        end else if (!running) begin
            if (tmr_bus.start) begin
                running <= 1'b1;
                cnt     <= '0;
                kind_q  <= tmr_bus.kind;
            end
        end else if (cnt == end_cnt) begin
            running <= 1'b0;  // idle again next cycle
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // high for E_PULSE_END - E_PULSE_START ticks
    assign tmr_bus.e_active = running && has_e_pulse(kind_q)
                              && (cnt >= CNT_W'(E_PULSE_START))
                              && (cnt <  CNT_W'(E_PULSE_END));

    assign tmr_bus.step_done = running && (cnt == end_cnt);

    // ========================================
    // checks
    // ========================================
    // a power-up kick must leave E low where the strobe would rise
    a_no_e_in_power_up: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(tmr_bus.start, E_PULSE_START + 1)
         && $past(tmr_bus.kind, E_PULSE_START + 1) == power_up)
        |-> !tmr_bus.e_active);

    // sequencer must wait for step_done before the next kick
    a_start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        tmr_bus.start |-> !running);

endmodule

/* tests/lcd_cases.txt */
// one character write per line, all values hex
// row  column  character  expected address byte
0 0 48 80
0 1 45 81
0 2 4C 82
0 3 4C 83
0 4 4F 84
0 F 21 8F
1 0 57 C0
1 1 6F C1
1 2 72 C2
1 7 6C C7
1 8 64 C8
1 F 3F CF
0 8 2A 88
1 A 7E CA

/* tests/tb_lcd_top.sv */
`timescale 1ns/1ps

module tb_lcd_top;
    import lcd_cmd_pkg::*;

    localparam int          CLK_HZ        = 2_000_000;
    localparam int          N_CASES       = 14;
    localparam int          E_HIGH_CYCLES = 20;
    localparam int          INIT_LIMIT    = 50_000;  // init is about 44900 cycles at 2 MHz
    localparam int          WRITE_LIMIT   = 1_000;   // two 50 us steps plus the E windows
    localparam logic [15:0] LFSR_SEED     = 16'd6112;
    localparam logic [15:0] LFSR_TAPS     = 16'hB400;

    logic             clk;
    logic             rst_n;
    logic             req;
    logic             row;
    logic [COL_W-1:0] col;
    logic [7:0]       char_code;
    logic             busy;
    logic             done;
    logic             lcd_e;
    logic             lcd_rs;
    logic             lcd_rw;
    logic [7:0]       lcd_data;

    // four words per case: row, column, character, address byte
    logic [7:0] case_mem [0:N_CASES*4-1];

    // bus writes seen by the monitor
    logic      mon_rs [$];
    lcd_word_u mon_word [$];
    int        e_len;

    logic [15:0] lfsr;

    lcd_top #(
        .CLK_HZ (CLK_HZ)
    ) u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .row       (row),
        .col       (col),
        .char_code (char_code),
        .busy      (busy),
        .done      (done),
        .lcd_e     (lcd_e),
        .lcd_rs    (lcd_rs),
        .lcd_rw    (lcd_rw),
        .lcd_data  (lcd_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    // ========================================
    // failure reporting
    // ========================================
    task automatic stop_run();
        $display("TB FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0t ns: %s", $time, msg);
        stop_run();
    endtask

    task automatic report_timeout(input string what);
        $display("timed out at %0t ns while waiting for %s", $time, what);
        stop_run();
    endtask

    // ========================================
    // compare tasks
    // ========================================
    task automatic check_byte(input lcd_word_u got, input lcd_word_u exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s is 0x%02h (flag %b addr 0x%02h), expected 0x%02h",
                what, got.instr, got.ddram.set_flag, got.ddram.addr, exp.instr));
        end
    endtask

    task automatic check_pin(input logic got, input logic exp, input string what);
        if (got !== exp)
            report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    task automatic check_level(input logic got_busy, input logic got_done,
                               input logic exp_busy, input logic exp_done,
                               input string what);
        if (got_busy !== exp_busy || got_done !== exp_done) begin
            report_mismatch($sformatf("%s: busy=%b done=%b, expected busy=%b done=%b",
                what, got_busy, got_done, exp_busy, exp_done));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp)
            report_mismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    // ========================================
    // helpers
    // ========================================
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0])
            return (s >> 1) ^ LFSR_TAPS;
        return s >> 1;
    endfunction

    // one LFSR step per bit taken
    task automatic take_bits(input int n, output int unsigned val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // set DDRAM address: line 2 starts at 0x40
    function automatic lcd_word_u addr_word(input logic r, input logic [COL_W-1:0] c);
        lcd_word_u w;
        w.ddram.set_flag = 1'b1;
        w.ddram.addr     = r ? (7'h40 + 7'(c)) : 7'(c);
        return w;
    endfunction

    task automatic wait_for_busy(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (busy !== level) begin
            if (n == limit)
                report_timeout(what);
            @(negedge clk);
            n++;
        end
    endtask

    task automatic wait_for_done(input int limit, input string what);
        int n;
        n = 0;
        while (done !== 1'b1) begin
            if (n == limit)
                report_timeout(what);
            @(negedge clk);
            n++;
        end
    endtask

    // ========================================
    // bus monitor
    // ========================================
    always @(negedge clk) begin
        check_pin(lcd_rw, 1'b0, "lcd_rw");
        if (lcd_e === 1'b1) begin
            e_len = e_len + 1;
        end else if (e_len != 0) begin  // E just fell
            check_count(e_len, E_HIGH_CYCLES, "E pulse width in cycles");
            mon_rs.push_back(lcd_rs);
            mon_word.push_back(lcd_word_u'(lcd_data));
            e_len = 0;
        end
    end

    // ========================================
    // stimulus
    // ========================================
    initial begin
        lcd_word_u        exp_word;
        logic [7:0]       init_codes [8];
        int unsigned      gap;
        int unsigned      hold;
        int               base;
        logic             c_row;
        logic [COL_W-1:0] c_col;
        logic [7:0]       c_char;
        logic [7:0]       c_addr;

        init_codes = '{8'h30, 8'h30, 8'h30, 8'h38, 8'h08, 8'h01, 8'h06, 8'h0C};
        rst_n      = 1'b0;
        req        = 1'b0;
        row        = 1'b0;
        col        = '0;
        char_code  = 8'h00;
        lfsr       = LFSR_SEED;
        $readmemh("tests/lcd_cases.txt", case_mem);

        repeat (3) @(negedge clk);
        check_level(busy, done, 1'b1, 1'b0, "during reset");
        check_pin(lcd_e, 1'b0, "lcd_e during reset");
        rst_n = 1'b1;
        @(negedge clk);
        check_level(busy, done, 1'b1, 1'b0, "after reset release");
        check_pin(lcd_e, 1'b0, "lcd_e after reset release");

        // power-up sequence runs on its own
        wait_for_busy(1'b0, INIT_LIMIT, "busy to fall after the init sequence");
        check_level(busy, done, 1'b0, 1'b0, "end of init");
        check_count(mon_word.size(), 8, "number of init writes");
        for (int i = 0; i < 8; i++) begin
            exp_word = lcd_word_u'(init_codes[i]);
            check_pin(mon_rs[i], 1'b0, $sformatf("rs of init write %0d", i));
            check_byte(mon_word[i], exp_word, $sformatf("init write %0d", i));
        end

        for (int k = 0; k < N_CASES; k++) begin
            c_row    = case_mem[4*k][0];
            c_col    = case_mem[4*k+1][COL_W-1:0];
            c_char   = case_mem[4*k+2];
            c_addr   = case_mem[4*k+3];
            exp_word = addr_word(c_row, c_col);
            check_byte(lcd_word_u'(c_addr), exp_word,
                       $sformatf("case %0d address byte in the cases file", k));

            take_bits(4, gap);
            repeat (gap) @(negedge clk);
            row       = c_row;
            col       = c_col;
            char_code = c_char;
            req       = 1'b1;
            base      = mon_word.size();
            @(negedge clk);
            check_level(busy, done, 1'b1, 1'b0, $sformatf("case %0d accepted", k));

            // req held while busy must not start another write
            take_bits(5, hold);
            repeat (hold) @(negedge clk);
            req       = 1'b0;
            row       = ~c_row;  // payload is latched by now
            col       = ~c_col;
            char_code = ~c_char;

            wait_for_done(WRITE_LIMIT, $sformatf("done of case %0d", k));
            check_level(busy, done, 1'b0, 1'b1, $sformatf("case %0d finished", k));
            @(negedge clk);
            check_level(busy, done, 1'b0, 1'b0, $sformatf("case %0d after done", k));

            check_count(mon_word.size() - base, 2, $sformatf("writes of case %0d", k));
            check_pin(mon_rs[base], 1'b0, $sformatf("case %0d rs of address write", k));
            check_byte(mon_word[base], exp_word, $sformatf("case %0d address write", k));
            exp_word = lcd_word_u'(c_char);
            check_pin(mon_rs[base+1], 1'b1, $sformatf("case %0d rs of data write", k));
            check_byte(mon_word[base+1], exp_word, $sformatf("case %0d data write", k));
        end

        // quiet bus after the last write
        repeat (50) @(negedge clk);
        if (mon_word.size() == 8 + 2 * N_CASES) begin
            $display("TB PASSED");
            $finish;
        end else begin
            report_mismatch($sformatf("%0d bus writes in total, expected %0d",
                mon_word.size(), 8 + 2 * N_CASES));
        end
    end

endmodule
